// ==== verilog/alu_defs.svh ====
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// datapath word
`define ALU_XLEN      32

// execution lanes, 2 to 8
`define ALU_LANES     4

// reorder slots, power of two
`define ALU_ROB_DEPTH 8

// log2 of ALU_ROB_DEPTH
`define ALU_TAG_W     3

`endif

// ==== verilog/alu_pkg.sv ====
`include "alu_defs.svh"
`default_nettype none

package alu_pkg;

    typedef enum logic [4:0] {
        AUIPC = 5'd0,
        ADD   = 5'd1,
        SUB   = 5'd2,
        AND   = 5'd3,
        OR    = 5'd4,
        XOR   = 5'd5,
        SLL   = 5'd6,
        SRL   = 5'd7,
        SRA   = 5'd8,
        SLT   = 5'd9,
        SLTU  = 5'd10,
        LUI   = 5'd11,
        BGE   = 5'd12,
        BGEU  = 5'd13,
        BLT   = 5'd14,
        BLTU  = 5'd15,
        BNE   = 5'd16,
        BEQ   = 5'd17,
        JAL   = 5'd18,
        JALR  = 5'd19
    } alu_op_e;

    // wraps, doubles as reorder slot index
    typedef logic [`ALU_TAG_W-1:0] alu_tag_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        SHIFT = 2'd1,
        DONE  = 2'd2
    } lane_state_e;

endpackage

`default_nettype wire

// ==== verilog/alu_issue.sv ====
`timescale 1ns/10ps
`include "alu_defs.svh"
`default_nettype none

module alu_issue
    import alu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [`ALU_LANES-1:0] lane_busy,
    input  logic                  retire,
    output logic                  ready,
    output logic [`ALU_LANES-1:0] lane_issue,
    output alu_tag_t              issue_tag
);

    logic [`ALU_LANES-1:0] lane_idle;
    logic [`ALU_LANES-1:0] first_idle;
    logic [`ALU_TAG_W:0]   in_flight;
    logic                  started;
    logic                  accept;

    assign lane_idle  = ~lane_busy;
    assign first_idle = lane_idle & (~lane_idle + 1'b1);   // lowest idle lane

    // ready stays low for the first cycle out of reset
    assign ready = started && (|lane_idle) && (in_flight < `ALU_ROB_DEPTH);

    assign accept     = in_valid && ready;
    assign lane_issue = accept ? first_idle : '0;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            started   <= 1'b0;
            in_flight <= '0;
            issue_tag <= '0;
        end
        else
        begin
            started <= 1'b1;
            if (accept)
            begin
                issue_tag <= issue_tag + 1'b1;   // wraps with the slots
            end
            case ({accept, retire})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;   // none or both
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alu_lane.sv ====
`timescale 1ns/10ps
`include "alu_defs.svh"
`default_nettype none

module alu_lane
    import alu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue,
    input  alu_op_e              op,
    input  logic [`ALU_XLEN-1:0] op1,
    input  logic [`ALU_XLEN-1:0] op2,
    input  logic [`ALU_XLEN-1:0] addr,
    input  alu_tag_t             tag,
    output logic                 busy,
    output logic                 done,
    output alu_tag_t             done_tag,
    output logic [`ALU_XLEN-1:0] result,
    output logic                 zero,
    output logic                 c_out,
    output logic                 overflow,
    output logic                 jalr_done,
    output logic [`ALU_XLEN-1:0] jalr_addr
);

    localparam int MSB = `ALU_XLEN - 1;

    lane_state_e         state;
    alu_op_e             op_q;
    logic [4:0]          cnt;
    logic [4:0]          shamt;
    logic                is_shift;
    logic                slt_flag;
    logic                ltu_flag;
    logic [`ALU_XLEN:0]  step_next;
    logic [`ALU_XLEN-1:0] c_result;
    logic                c_zero;
    logic                c_c_out;
    logic                c_overflow;
    logic                c_jalr_done;
    logic [`ALU_XLEN-1:0] c_jalr_addr;

    // one bit position, returns {bit shifted out, new value}
    function automatic logic [`ALU_XLEN:0] shift_step(input alu_op_e sop,
                                                      input logic [`ALU_XLEN-1:0] val);
        logic [`ALU_XLEN:0] res;
        case (sop)
            SLL:     res = {val, 1'b0};
            SRL:     res = {val[0], 1'b0, val[MSB:1]};
            default: res = {val[0], val[MSB], val[MSB:1]};   // sra
        endcase
        return res;
    endfunction

    assign shamt    = op2[4:0];
    assign is_shift = (op == SLL) || (op == SRL) || (op == SRA);
    assign slt_flag = (op1[MSB] != op2[MSB]) ? op1[MSB] : (op1 < op2);   // sign bits first
    assign ltu_flag = (op1 < op2);

    assign step_next = shift_step(op_q, result);

    assign busy = (state != IDLE);
    assign done = (state == DONE);

    always_comb
    begin
        c_result    = '0;
        c_zero      = 1'b0;
        c_c_out     = 1'b0;
        c_overflow  = 1'b0;
        c_jalr_done = 1'b0;
        c_jalr_addr = '0;
        case (op)
            AUIPC:
            begin
                c_result   = addr + op2;
                c_overflow = (addr[MSB] == op2[MSB]) && (c_result[MSB] != addr[MSB]);
                c_zero     = (c_result == '0);
            end
            ADD:
            begin
                c_result   = op1 + op2;
                c_overflow = (op1[MSB] == op2[MSB]) && (c_result[MSB] != op1[MSB]);
                c_zero     = (c_result == '0);
            end
            SUB:
            begin
                c_result   = op1 - op2;
                c_overflow = (op1[MSB] != op2[MSB]) && (c_result[MSB] != op1[MSB]);
                c_zero     = (op1 == op2);
            end
            AND, OR, XOR:
            begin
                if (op == AND)
                    c_result = op1 & op2;
                else if (op == OR)
                    c_result = op1 | op2;
                else
                    c_result = op1 ^ op2;
                c_zero = (c_result == '0);
            end
            SLL, SRL, SRA:
            begin
                // first bit goes at issue, the rest in SHIFT
                if (shamt == 5'd0)
                    c_result = op1;
                else
                    {c_c_out, c_result} = shift_step(op, op1);
                c_zero = (c_result == '0);
            end
            SLT, SLTU:
            begin
                c_result = {{MSB{1'b0}}, (op == SLT) ? slt_flag : ltu_flag};
                c_zero   = ~c_result[0];
                c_c_out  = c_result[0];
            end
            LUI:
            begin
                c_result = op2;
                c_zero   = (op2 == '0);
            end
            BGE, BGEU, BLT, BLTU, BNE, BEQ:
            begin
                case (op)
                    BGE:     c_result[0] = ~slt_flag;
                    BGEU:    c_result[0] = ~ltu_flag;
                    BLT:     c_result[0] = slt_flag;
                    BLTU:    c_result[0] = ltu_flag;
                    BNE:     c_result[0] = (op1 != op2);
                    default: c_result[0] = (op1 == op2);   // beq
                endcase
                c_zero = ~c_result[0];
            end
            default:
            begin
                c_result    = addr + 32'd4;   // jal, jalr link
                c_jalr_done = (op == JALR);
                c_jalr_addr = (op == JALR) ? op1 + op2 : '0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (issue && is_shift && shamt > 5'd1)
                        state <= SHIFT;
                    else if (issue)
                        state <= DONE;
                end
                SHIFT:
                begin
                    if (cnt == 5'd1)
                        state <= DONE;   // last bit this cycle
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue && state == IDLE)
        begin
            op_q      <= op;
            cnt       <= shamt - 5'd1;
            done_tag  <= tag;
            result    <= c_result;
            zero      <= c_zero;
            c_out     <= c_c_out;
            overflow  <= c_overflow;
            jalr_done <= c_jalr_done;
            jalr_addr <= c_jalr_addr;
        end
        else if (state == SHIFT)
        begin
            {c_out, result} <= step_next;
            zero            <= (step_next[MSB:0] == '0);
            cnt             <= cnt - 5'd1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alu_reorder.sv ====
`timescale 1ns/10ps
`include "alu_defs.svh"
`default_nettype none

module alu_reorder
    import alu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 lane_done      [`ALU_LANES],
    input  alu_tag_t             lane_tag       [`ALU_LANES],
    input  logic [`ALU_XLEN-1:0] lane_result    [`ALU_LANES],
    input  logic                 lane_zero      [`ALU_LANES],
    input  logic                 lane_c_out     [`ALU_LANES],
    input  logic                 lane_overflow  [`ALU_LANES],
    input  logic                 lane_jalr_done [`ALU_LANES],
    input  logic [`ALU_XLEN-1:0] lane_jalr_addr [`ALU_LANES],
    output logic                 retire,
    output logic                 out_valid,
    output logic [`ALU_XLEN-1:0] out_result,
    output logic                 out_zero,
    output logic                 out_c_out,
    output logic                 out_overflow,
    output logic                 jump_valid,
    output logic [`ALU_XLEN-1:0] jump_addr
);

    logic [`ALU_ROB_DEPTH-1:0] slot_valid;
    logic [`ALU_XLEN-1:0]      slot_result [`ALU_ROB_DEPTH];
    logic                      slot_zero   [`ALU_ROB_DEPTH];
    logic                      slot_c_out  [`ALU_ROB_DEPTH];
    logic                      slot_ovf    [`ALU_ROB_DEPTH];
    logic                      slot_jalr   [`ALU_ROB_DEPTH];
    logic [`ALU_XLEN-1:0]      slot_target [`ALU_ROB_DEPTH];
    alu_tag_t                  head;
    logic                      ret_jalr;

    assign retire     = out_valid;
    assign jump_valid = out_valid && ret_jalr;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            slot_valid <= '0;
            head       <= '0;
            out_valid  <= 1'b0;
        end
        else
        begin
            out_valid <= slot_valid[head];
            if (slot_valid[head])
            begin
                slot_valid[head] <= 1'b0;
                head             <= head + 1'b1;
            end
            // tags in flight never alias the head being retired
            for (int i = 0; i < `ALU_LANES; i++)
            begin
                if (lane_done[i])
                    slot_valid[lane_tag[i]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `ALU_LANES; i++)
        begin
            if (lane_done[i])
            begin
                slot_result[lane_tag[i]] <= lane_result[i];
                slot_zero[lane_tag[i]]   <= lane_zero[i];
                slot_c_out[lane_tag[i]]  <= lane_c_out[i];
                slot_ovf[lane_tag[i]]    <= lane_overflow[i];
                slot_jalr[lane_tag[i]]   <= lane_jalr_done[i];
                slot_target[lane_tag[i]] <= lane_jalr_addr[i];
            end
        end
        if (slot_valid[head])
        begin
            out_result   <= slot_result[head];
            out_zero     <= slot_zero[head];
            out_c_out    <= slot_c_out[head];
            out_overflow <= slot_ovf[head];
            ret_jalr     <= slot_jalr[head];
            jump_addr    <= slot_target[head];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alu_cluster.sv ====
`timescale 1ns/10ps
`include "alu_defs.svh"
`default_nettype none

module alu_cluster
    import alu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  alu_op_e              in_op,
    input  logic [`ALU_XLEN-1:0] in_op1,
    input  logic [`ALU_XLEN-1:0] in_op2,
    input  logic [`ALU_XLEN-1:0] in_addr,
    output logic                 ready,
    output logic                 out_valid,
    output logic [`ALU_XLEN-1:0] out_result,
    output logic                 out_zero,
    output logic                 out_c_out,
    output logic                 out_overflow,
    output logic                 jump_valid,
    output logic [`ALU_XLEN-1:0] jump_addr
);

    logic [`ALU_LANES-1:0] lane_busy;
    logic [`ALU_LANES-1:0] lane_issue;
    alu_tag_t              issue_tag;
    logic                  retire;

    logic                 lane_done      [`ALU_LANES];
    alu_tag_t             lane_tag       [`ALU_LANES];
    logic [`ALU_XLEN-1:0] lane_result    [`ALU_LANES];
    logic                 lane_zero      [`ALU_LANES];
    logic                 lane_c_out     [`ALU_LANES];
    logic                 lane_overflow  [`ALU_LANES];
    logic                 lane_jalr_done [`ALU_LANES];
    logic [`ALU_XLEN-1:0] lane_jalr_addr [`ALU_LANES];

    alu_issue i_alu_issue (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .lane_busy  (lane_busy),
        .retire     (retire),
        .ready      (ready),
        .lane_issue (lane_issue),
        .issue_tag  (issue_tag)
    );

    // operands broadcast, issue pulse selects the lane
    for (genvar g = 0; g < `ALU_LANES; g++)
    begin : g_lane
        alu_lane i_alu_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .issue     (lane_issue[g]),
            .op        (in_op),
            .op1       (in_op1),
            .op2       (in_op2),
            .addr      (in_addr),
            .tag       (issue_tag),
            .busy      (lane_busy[g]),
            .done      (lane_done[g]),
            .done_tag  (lane_tag[g]),
            .result    (lane_result[g]),
            .zero      (lane_zero[g]),
            .c_out     (lane_c_out[g]),
            .overflow  (lane_overflow[g]),
            .jalr_done (lane_jalr_done[g]),
            .jalr_addr (lane_jalr_addr[g])
        );
    end

    alu_reorder i_alu_reorder (
        .clk            (clk),
        .rst_n          (rst_n),
        .lane_done      (lane_done),
        .lane_tag       (lane_tag),
        .lane_result    (lane_result),
        .lane_zero      (lane_zero),
        .lane_c_out     (lane_c_out),
        .lane_overflow  (lane_overflow),
        .lane_jalr_done (lane_jalr_done),
        .lane_jalr_addr (lane_jalr_addr),
        .retire         (retire),
        .out_valid      (out_valid),
        .out_result     (out_result),
        .out_zero       (out_zero),
        .out_c_out      (out_c_out),
        .out_overflow   (out_overflow),
        .jump_valid     (jump_valid),
        .jump_addr      (jump_addr)
    );

endmodule

`default_nettype wire

// ==== sim/alu_cluster_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_cluster_assertions (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic ready,
    input logic out_valid,
    input logic jump_valid
);

    localparam int MAX_LATENCY = 40;

    int unsigned cycle_cnt;
    int unsigned accept_cycle [16];
    logic [3:0]  wr_ptr;
    logic [3:0]  rd_ptr;

    // acceptance times, oldest first since retirement is in order
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cycle_cnt <= 0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
        end
        else
        begin
            cycle_cnt <= cycle_cnt + 1;
            if (in_valid && ready)
            begin
                accept_cycle[wr_ptr] <= cycle_cnt;
                wr_ptr               <= wr_ptr + 1'b1;
            end
            if (out_valid)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assert property (@(posedge clk) $rose(rst_n) |-> !out_valid && !jump_valid && !ready)
        else $error("out_valid, jump_valid or ready high in the first cycle after reset");

    assert property (@(posedge clk) disable iff (!rst_n) jump_valid |-> out_valid)
        else $error("jump_valid without out_valid");

    assert property (@(posedge clk) disable iff (!rst_n)
                     (wr_ptr != rd_ptr) |-> (cycle_cnt - accept_cycle[rd_ptr] <= MAX_LATENCY))
        else $error("accepted operation not retired within 40 cycles");

endmodule

bind alu_cluster alu_cluster_assertions i_alu_cluster_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .ready      (ready),
    .out_valid  (out_valid),
    .jump_valid (jump_valid)
);

`default_nettype wire

// ==== sim/alu_cluster_tb.sv ====
`timescale 1ns/10ps
`include "alu_defs.svh"
`default_nettype none

module alu_cluster_tb
    import alu_pkg::*;
();

    localparam int NUM_OPS     = 2000;
    localparam int STALL_LIMIT = 100;
    localparam int DRAIN_LIMIT = 200;

    typedef struct packed {
        alu_op_e              op;
        logic [`ALU_XLEN-1:0] result;
        logic                 zero;
        logic                 c_out;
        logic                 overflow;
        logic                 jump;
        logic [`ALU_XLEN-1:0] target;
    } expect_t;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    alu_op_e              in_op;
    logic [`ALU_XLEN-1:0] in_op1;
    logic [`ALU_XLEN-1:0] in_op2;
    logic [`ALU_XLEN-1:0] in_addr;
    logic                 ready;
    logic                 out_valid;
    logic [`ALU_XLEN-1:0] out_result;
    logic                 out_zero;
    logic                 out_c_out;
    logic                 out_overflow;
    logic                 jump_valid;
    logic [`ALU_XLEN-1:0] jump_addr;

    logic [31:0]          lfsr_state;
    alu_op_e              cur_op;
    logic [`ALU_XLEN-1:0] cur_op1;
    logic [`ALU_XLEN-1:0] cur_op2;
    logic [`ALU_XLEN-1:0] cur_pc;
    logic                 ready_seen;
    logic                 full_seen;
    expect_t              expected_q [$];
    int                   lane_release [$];
    int                   cycle;
    int                   accepted;
    int                   retired;

    alu_cluster i_alu_cluster (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_op1       (in_op1),
        .in_op2       (in_op2),
        .in_addr      (in_addr),
        .ready        (ready),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .out_zero     (out_zero),
        .out_c_out    (out_c_out),
        .out_overflow (out_overflow),
        .jump_valid   (jump_valid),
        .jump_addr    (jump_addr)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // cycles a lane stays busy, serial shifts take one per bit
    function automatic int lane_cycles(input alu_op_e op, input logic [31:0] b);
        if ((op == SLL || op == SRL || op == SRA) && b[4:0] > 5'd1)
            return int'(b[4:0]);
        return 1;
    endfunction

    function automatic expect_t model_op(input alu_op_e op, input logic [31:0] a,
                                         input logic [31:0] b, input logic [31:0] pc);
        expect_t     e;
        logic [32:0] sum;
        int          sh;
        e    = '0;
        e.op = op;
        sh   = int'(b[4:0]);
        case (op)
            AUIPC:   sum = {pc[31], pc} + {b[31], b};
            ADD:     sum = {a[31], a} + {b[31], b};
            SUB:     sum = {a[31], a} - {b[31], b};
            default: sum = '0;
        endcase
        case (op)
            AUIPC, ADD, SUB:
            begin
                e.result   = sum[31:0];
                e.overflow = sum[32] ^ sum[31];   // sign-extended carry disagrees
            end
            AND:     e.result = a & b;
            OR:      e.result = a | b;
            XOR:     e.result = a ^ b;
            SLL:     e.result = a << sh;
            SRL:     e.result = a >> sh;
            SRA:     e.result = $signed(a) >>> sh;
            SLT:     e.result = {31'b0, ($signed(a) < $signed(b))};
            SLTU:    e.result = {31'b0, (a < b)};
            LUI:     e.result = b;
            BGE:     e.result = {31'b0, ($signed(a) >= $signed(b))};
            BGEU:    e.result = {31'b0, (a >= b)};
            BLT:     e.result = {31'b0, ($signed(a) < $signed(b))};
            BLTU:    e.result = {31'b0, (a < b)};
            BNE:     e.result = {31'b0, (a != b)};
            BEQ:     e.result = {31'b0, (a == b)};
            default: e.result = pc + 32'd4;   // link address
        endcase
        e.zero = (e.result == '0);
        if (op == SLL && sh != 0)
            e.c_out = a[32 - sh];
        if ((op == SRL || op == SRA) && sh != 0)
            e.c_out = a[sh - 1];
        if (op == SLT || op == SLTU)
            e.c_out = e.result[0];
        if (op == JAL || op == JALR)
            e.zero = 1'b0;
        if (op == JALR)
        begin
            e.jump   = 1'b1;
            e.target = a + b;
        end
        return e;
    endfunction

    task automatic stop_with_failure();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic pick_op();
        logic [4:0] code;
        code    = 5'(take_bits(5) % 32'd20);
        cur_op  = alu_op_e'(code);
        cur_op1 = take_bits(32);
        cur_op2 = take_bits(32);
        cur_pc  = take_bits(32);
        case (2'(take_bits(2)))
            2'd0:    cur_op2 = cur_op1;
            2'd1:    cur_op2[31] = ~cur_op1[31];   // opposite signs
            default: cur_op2 = cur_op2;
        endcase
        if ((cur_op == SLL || cur_op == SRL || cur_op == SRA) && take_bits(8) % 32'd3 == 0)
            cur_op2[4:0] = 5'(take_bits(2));   // short shift
        in_valid <= 1'b1;
        in_op    <= cur_op;
        in_op1   <= cur_op1;
        in_op2   <= cur_op2;
        in_addr  <= cur_pc;
    endtask

    // one clock edge, retirement checked against the queue head
    task automatic tick();
        expect_t e;
        alu_op_e op_r;
        string   tag;
        logic    exp_ready;
        @(posedge clk);
        cycle++;
        ready_seen = ready;
        // a lane stays busy up to and including its done cycle
        for (int i = lane_release.size() - 1; i >= 0; i--)
        begin
            if (lane_release[i] < cycle)
                lane_release.delete(i);
        end
        if (accepted - retired >= `ALU_ROB_DEPTH)
            full_seen = 1'b1;
        exp_ready = (cycle > 1) && (lane_release.size() < `ALU_LANES)
                    && (accepted - retired < `ALU_ROB_DEPTH);
        check_value(32'(ready), 32'(exp_ready), "ready against free lanes and slots");
        if (out_valid && expected_q.size() == 0)
        begin
            $display("out_valid at %0t with no operation in flight", $time);
            stop_with_failure();
        end
        else if (out_valid)
        begin
            e    = expected_q.pop_front();
            op_r = e.op;
            tag  = $sformatf("retire %0d %s", retired, op_r.name());
            check_value(out_result, e.result, {tag, " result"});
            check_value(32'(out_zero), 32'(e.zero), {tag, " zero"});
            check_value(32'(out_c_out), 32'(e.c_out), {tag, " c_out"});
            check_value(32'(out_overflow), 32'(e.overflow), {tag, " overflow"});
            check_value(32'(jump_valid), 32'(e.jump), {tag, " jump_valid"});
            if (e.jump)
                check_value(jump_addr, e.target, {tag, " jump_addr"});
            retired++;
        end
        else if (jump_valid)
        begin
            $display("jump_valid at %0t without out_valid", $time);
            stop_with_failure();
        end
    endtask

    initial
    begin
        int waited;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_op      = ADD;
        in_op1     = '0;
        in_op2     = '0;
        in_addr    = '0;
        lfsr_state = 32'hc7ec_887f;
        ready_seen = 1'b0;
        full_seen  = 1'b0;
        cycle      = 0;
        accepted   = 0;
        retired    = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        while (accepted < NUM_OPS)
        begin
            if (take_bits(3) == 32'd0)
            begin
                in_valid <= 1'b0;   // idle gap
                tick();
            end
            pick_op();
            waited = 0;
            tick();
            while (!(ready_seen && in_valid) && waited < STALL_LIMIT)
            begin
                waited++;
                tick();
            end
            if (!(ready_seen && in_valid))
            begin
                $display("ready stayed low for %0d cycles at %0t", STALL_LIMIT, $time);
                stop_with_failure();
            end
            expected_q.push_back(model_op(cur_op, cur_op1, cur_op2, cur_pc));
            lane_release.push_back(cycle + lane_cycles(cur_op, cur_op2));
            accepted++;
        end
        in_valid <= 1'b0;
        waited = 0;
        while (retired < accepted && waited < DRAIN_LIMIT)
        begin
            waited++;
            tick();
        end
        if (retired < accepted)
        begin
            $display("only %0d of %0d operations retired", retired, accepted);
            stop_with_failure();
        end
        repeat (10) tick();   // catch stray retirements
        if (retired == accepted && expected_q.size() == 0 && full_seen)
        begin
            $display("** PASS **");
            $finish;
        end
        else
        begin
            $display("reorder buffer never filled, or counts differ: %0d accepted %0d retired",
                     accepted, retired);
            $display("** FAIL **");
            $fatal(1, "simulation ended with an error");
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu_issue.sv
verilog/alu_lane.sv
verilog/alu_reorder.sv
verilog/alu_cluster.sv
sim/alu_cluster_assertions.sv
sim/alu_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module alu_cluster_tb -f verilog.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Valu_cluster_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

exit 0
